// ==== hw/mem_pkg.sv ====
// mem_pkg shared widths, data RAM size and the enums of the memory subsystem

package mem_pkg;

  // datapath and register widths
  localparam int WORD_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  // data RAM, 1 KiB at address 0
  localparam int DMEM_WORDS  = 256;
  localparam int DMEM_AW     = 8;    // word index width

  // load/store size and sign, same codes as funct3
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_op_e;

  // APB master phases
  typedef enum logic [1:0] {
    LSU_IDLE   = 2'd0,
    LSU_SETUP  = 2'd1,
    LSU_ACCESS = 2'd2
  } lsu_state_e;

endpackage

// ==== hw/data_ram.sv ====
// data RAM, APB slave with byte strobes, one read wait state and range error

`timescale 1ns/10ps

module data_ram
  import mem_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  logic [WORD_WD-1:0] i_paddr,
  input  logic [WORD_WD-1:0] i_pwdata,
  input  logic [3:0]         i_pstrb,
  output logic [WORD_WD-1:0] o_prdata,
  output logic               o_pready,
  output logic               o_pslverr
);

  logic [WORD_WD-1:0] mem [DMEM_WORDS];
  logic [WORD_WD-1:0] rdata_q;
  logic               rd_wait;        // read data captured, answer now
  logic               access;
  logic               in_range;
  logic [DMEM_AW-1:0] idx;

  assign access   = i_psel && i_penable;
  assign in_range = i_paddr < (DMEM_WORDS * 4);
  assign idx      = i_paddr[DMEM_AW+1:2];

  assign o_pready  = access && (i_pwrite || rd_wait || !in_range);
  assign o_pslverr = access && !in_range;
  assign o_prdata  = (in_range && rd_wait) ? rdata_q : '0;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n)
      rd_wait <= 1'b0;
    else if (o_pready)
      rd_wait <= 1'b0;
    else if (access && !i_pwrite && in_range)
      rd_wait <= 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (access && !i_pwrite && in_range && !rd_wait)
      rdata_q <= mem[idx];
    if (access && i_pwrite && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (i_pstrb[b])
          mem[idx][b*8 +: 8] <= i_pwdata[b*8 +: 8];
      end
    end
  end

  a_enable_needs_sel: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_penable |-> i_psel);

endmodule

// ==== hw/lsu.sv ====
// load/store unit, APB master with store lane placement, load extension and access checks

`timescale 1ns/10ps

module lsu
  import mem_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst_n,
  // request from ms
  input  logic               i_req,
  input  logic               i_write,
  input  mem_op_e            i_op,
  input  logic [WORD_WD-1:0] i_addr,
  input  logic [WORD_WD-1:0] i_wdata,
  output logic               o_done,
  output logic [WORD_WD-1:0] o_rdata,
  output logic               o_err,
  // apb master
  output logic               o_psel,
  output logic               o_penable,
  output logic               o_pwrite,
  output logic [WORD_WD-1:0] o_paddr,
  output logic [WORD_WD-1:0] o_pwdata,
  output logic [3:0]         o_pstrb,
  input  logic [WORD_WD-1:0] i_prdata,
  input  logic               i_pready,
  input  logic               i_pslverr
);

  lsu_state_e         state;
  logic               bad_done;      // misaligned, answered without a bus cycle
  mem_op_e            op_q;
  logic               misalign;
  logic               start;
  logic [WORD_WD-1:0] st_data;
  logic [3:0]         st_strb;
  logic               bus_done;
  logic [WORD_WD-1:0] lane;
  logic [WORD_WD-1:0] ld_ext;

  always_comb begin
    case (i_op)
      MEM_B, MEM_BU: misalign = 1'b0;
      MEM_H, MEM_HU: misalign = i_addr[0];
      default:       misalign = |i_addr[1:0];
    endcase
  end

  // replicate store data, strobe picks the lanes
  always_comb begin
    case (i_op)
      MEM_B, MEM_BU: begin
        st_data = {4{i_wdata[7:0]}};
        st_strb = 4'b0001 << i_addr[1:0];
      end
      MEM_H, MEM_HU: begin
        st_data = {2{i_wdata[15:0]}};
        st_strb = 4'b0011 << {i_addr[1], 1'b0};
      end
      default: begin
        st_data = i_wdata;
        st_strb = 4'b1111;
      end
    endcase
  end

  assign start = (state == LSU_IDLE) && i_req && !bad_done;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state    <= LSU_IDLE;
      bad_done <= 1'b0;
    end else begin
      bad_done <= start && misalign;
      case (state)
        LSU_IDLE: begin
          if (start && !misalign)
            state <= LSU_SETUP;
        end
        LSU_SETUP:  state <= LSU_ACCESS;
        LSU_ACCESS: begin
          if (i_pready)
            state <= LSU_IDLE;
        end
        default:    state <= LSU_IDLE;
      endcase
    end
  end

  // bus fields, stable from setup to the end of access
  always_ff @(posedge i_clk) begin
    if (start && !misalign) begin
      o_paddr  <= i_addr;
      o_pwrite <= i_write;
      o_pwdata <= st_data;
      o_pstrb  <= i_write ? st_strb : 4'b0000;
      op_q     <= i_op;
    end
  end

  assign o_psel    = (state != LSU_IDLE);
  assign o_penable = (state == LSU_ACCESS);

  assign bus_done = (state == LSU_ACCESS) && i_pready;
  assign o_done   = bus_done || bad_done;
  assign o_err    = bad_done || (bus_done && i_pslverr);

  // move the addressed byte/half down to bit 0
  assign lane = i_prdata >> {o_paddr[1:0], 3'b000};

  always_comb begin
    case (op_q)
      MEM_B:   ld_ext = {{24{lane[7]}}, lane[7:0]};
      MEM_BU:  ld_ext = {24'b0, lane[7:0]};
      MEM_H:   ld_ext = {{16{lane[15]}}, lane[15:0]};
      MEM_HU:  ld_ext = {16'b0, lane[15:0]};
      default: ld_ext = lane;
    endcase
  end

  assign o_rdata = o_err ? '0 : ld_ext;

  // request held by the memory stage until done
  a_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_req && !o_done) |=> (i_req && $stable(i_addr) && $stable(i_write) && $stable(i_op)));

  a_bus_matches_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_psel |-> (i_req && o_paddr == i_addr && o_pwrite == i_write));

endmodule

// ==== hw/mem_stage.sv ====
// memory stage, holds one instruction, runs its load/store and registers the write-back result

`timescale 1ns/10ps

module mem_stage
  import mem_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  // from es
  input  logic                   i_es_valid,
  input  logic [GPR_ADDR_WD-1:0] i_rd,
  input  logic [CSR_ADDR_WD-1:0] i_csr,
  input  logic                   i_gpr_wen,
  input  logic                   i_csr_wen,
  input  logic                   i_mem_ren,
  input  logic                   i_mem_wen,
  input  mem_op_e                i_mem_op,
  input  logic                   i_csr_inst_sel,   // write csrrdata to gpr
  input  logic [WORD_WD-1:0]     i_rs2data,
  input  logic [WORD_WD-1:0]     i_csrrdata,
  input  logic [WORD_WD-1:0]     i_alu_result,
  input  logic [WORD_WD-1:0]     i_csr_result,
  output logic                   o_ms_allow_in,
  // to ws
  output logic                   o_ws_valid,
  output logic                   o_ws_gpr_wen,
  output logic [GPR_ADDR_WD-1:0] o_ws_rd,
  output logic [WORD_WD-1:0]     o_ws_gpr_data,
  output logic                   o_ws_csr_wen,
  output logic [CSR_ADDR_WD-1:0] o_ws_csr,
  output logic [WORD_WD-1:0]     o_ws_csr_data,
  output logic                   o_ws_mem_err,
  input  logic                   i_ws_allow_in,
  // to lsu
  output logic                   o_lsu_req,
  output logic                   o_lsu_write,
  output mem_op_e                o_lsu_op,
  output logic [WORD_WD-1:0]     o_lsu_addr,
  output logic [WORD_WD-1:0]     o_lsu_wdata,
  input  logic                   i_lsu_done,
  input  logic [WORD_WD-1:0]     i_lsu_rdata,
  input  logic                   i_lsu_err
);

  logic                   ms_valid;
  logic                   ms_done;          // lsu finished, result parked
  logic [GPR_ADDR_WD-1:0] ms_rd;
  logic [CSR_ADDR_WD-1:0] ms_csr;
  logic                   ms_gpr_wen;
  logic                   ms_csr_wen;
  logic                   ms_mem_ren;
  logic                   ms_mem_wen;
  mem_op_e                ms_mem_op;
  logic                   ms_csr_inst_sel;
  logic [WORD_WD-1:0]     ms_rs2data;
  logic [WORD_WD-1:0]     ms_csrrdata;
  logic [WORD_WD-1:0]     ms_alu_result;
  logic [WORD_WD-1:0]     ms_csr_result;
  logic [WORD_WD-1:0]     ld_data_q;
  logic                   ld_err_q;

  logic                   is_mem;
  logic                   ms_ready_go;
  logic                   ws_free;
  logic                   ms_to_ws;
  logic [WORD_WD-1:0]     ld_data;
  logic                   mem_err;
  logic [WORD_WD-1:0]     gpr_final;

  assign is_mem      = ms_mem_ren | ms_mem_wen;
  assign ms_ready_go = !is_mem || ms_done || i_lsu_done;
  assign ws_free     = !o_ws_valid || i_ws_allow_in;
  assign ms_to_ws    = ms_valid && ms_ready_go && ws_free;
  assign o_ms_allow_in = !ms_valid || ms_to_ws;

  // lsu request, held until done
  assign o_lsu_req   = ms_valid && is_mem && !ms_done;
  assign o_lsu_write = ms_mem_wen;
  assign o_lsu_op    = ms_mem_op;
  assign o_lsu_addr  = ms_alu_result;  // x[rs1] + imm
  assign o_lsu_wdata = ms_rs2data;

  assign ld_data = ms_done ? ld_data_q : i_lsu_rdata;
  assign mem_err = is_mem && (ms_done ? ld_err_q : i_lsu_err);

  always_comb begin
    if (mem_err)
      gpr_final = '0;
    else if (ms_mem_ren)
      gpr_final = ld_data;
    else if (ms_csr_inst_sel)
      gpr_final = ms_csrrdata;
    else
      gpr_final = ms_alu_result;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
      ms_done  <= 1'b0;
    end else begin
      if (o_ms_allow_in)
        ms_valid <= i_es_valid;
      if (o_ms_allow_in)
        ms_done <= 1'b0;
      else if (i_lsu_done)
        ms_done <= 1'b1;  // ws stalled, park the result
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_valid && o_ms_allow_in) begin
      ms_rd           <= i_rd;
      ms_csr          <= i_csr;
      ms_gpr_wen      <= i_gpr_wen;
      ms_csr_wen      <= i_csr_wen;
      ms_mem_ren      <= i_mem_ren;
      ms_mem_wen      <= i_mem_wen;
      ms_mem_op       <= i_mem_op;
      ms_csr_inst_sel <= i_csr_inst_sel;
      ms_rs2data      <= i_rs2data;
      ms_csrrdata     <= i_csrrdata;
      ms_alu_result   <= i_alu_result;
      ms_csr_result   <= i_csr_result;
    end
    if (i_lsu_done) begin
      ld_data_q <= i_lsu_rdata;
      ld_err_q  <= i_lsu_err;
    end
  end

  // write-back output register
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ws_valid   <= 1'b0;
      o_ws_gpr_wen <= 1'b0;
      o_ws_csr_wen <= 1'b0;
      o_ws_mem_err <= 1'b0;
    end else if (ws_free) begin
      o_ws_valid <= ms_valid && ms_ready_go;
      if (ms_to_ws) begin
        o_ws_gpr_wen <= ms_gpr_wen;
        o_ws_csr_wen <= ms_csr_wen;
        o_ws_mem_err <= mem_err;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (ms_to_ws) begin
      o_ws_rd       <= ms_rd;
      o_ws_gpr_data <= gpr_final;
      o_ws_csr      <= ms_csr;
      o_ws_csr_data <= ms_csr_result;  // csr result passes through
    end
  end

  // a done only answers a pending request
  a_done_for_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_lsu_done |-> o_lsu_req);

endmodule

// ==== hw/mem_subsys.sv ====
// memory subsystem top, memory stage with its load/store unit and data RAM

`timescale 1ns/10ps

module mem_subsys
  import mem_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  // from es
  input  logic                   i_es_valid,
  input  logic [GPR_ADDR_WD-1:0] i_rd,
  input  logic [CSR_ADDR_WD-1:0] i_csr,
  input  logic                   i_gpr_wen,
  input  logic                   i_csr_wen,
  input  logic                   i_mem_ren,
  input  logic                   i_mem_wen,
  input  mem_op_e                i_mem_op,
  input  logic                   i_csr_inst_sel,
  input  logic [WORD_WD-1:0]     i_rs2data,
  input  logic [WORD_WD-1:0]     i_csrrdata,
  input  logic [WORD_WD-1:0]     i_alu_result,
  input  logic [WORD_WD-1:0]     i_csr_result,
  output logic                   o_ms_allow_in,
  // to ws
  output logic                   o_ws_valid,
  output logic                   o_ws_gpr_wen,
  output logic [GPR_ADDR_WD-1:0] o_ws_rd,
  output logic [WORD_WD-1:0]     o_ws_gpr_data,
  output logic                   o_ws_csr_wen,
  output logic [CSR_ADDR_WD-1:0] o_ws_csr,
  output logic [WORD_WD-1:0]     o_ws_csr_data,
  output logic                   o_ws_mem_err,
  input  logic                   i_ws_allow_in
);

  logic               lsu_req;
  logic               lsu_write;
  mem_op_e            lsu_op;
  logic [WORD_WD-1:0] lsu_addr;
  logic [WORD_WD-1:0] lsu_wdata;
  logic               lsu_done;
  logic [WORD_WD-1:0] lsu_rdata;
  logic               lsu_err;

  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [WORD_WD-1:0] paddr;
  logic [WORD_WD-1:0] pwdata;
  logic [3:0]         pstrb;
  logic [WORD_WD-1:0] prdata;
  logic               pready;
  logic               pslverr;

  mem_stage u_mem_stage (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_es_valid     (i_es_valid),
    .i_rd           (i_rd),
    .i_csr          (i_csr),
    .i_gpr_wen      (i_gpr_wen),
    .i_csr_wen      (i_csr_wen),
    .i_mem_ren      (i_mem_ren),
    .i_mem_wen      (i_mem_wen),
    .i_mem_op       (i_mem_op),
    .i_csr_inst_sel (i_csr_inst_sel),
    .i_rs2data      (i_rs2data),
    .i_csrrdata     (i_csrrdata),
    .i_alu_result   (i_alu_result),
    .i_csr_result   (i_csr_result),
    .o_ms_allow_in  (o_ms_allow_in),
    .o_ws_valid     (o_ws_valid),
    .o_ws_gpr_wen   (o_ws_gpr_wen),
    .o_ws_rd        (o_ws_rd),
    .o_ws_gpr_data  (o_ws_gpr_data),
    .o_ws_csr_wen   (o_ws_csr_wen),
    .o_ws_csr       (o_ws_csr),
    .o_ws_csr_data  (o_ws_csr_data),
    .o_ws_mem_err   (o_ws_mem_err),
    .i_ws_allow_in  (i_ws_allow_in),
    .o_lsu_req      (lsu_req),
    .o_lsu_write    (lsu_write),
    .o_lsu_op       (lsu_op),
    .o_lsu_addr     (lsu_addr),
    .o_lsu_wdata    (lsu_wdata),
    .i_lsu_done     (lsu_done),
    .i_lsu_rdata    (lsu_rdata),
    .i_lsu_err      (lsu_err)
  );

  lsu u_lsu (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_req     (lsu_req),
    .i_write   (lsu_write),
    .i_op      (lsu_op),
    .i_addr    (lsu_addr),
    .i_wdata   (lsu_wdata),
    .o_done    (lsu_done),
    .o_rdata   (lsu_rdata),
    .o_err     (lsu_err),
    .o_psel    (psel),
    .o_penable (penable),
    .o_pwrite  (pwrite),
    .o_paddr   (paddr),
    .o_pwdata  (pwdata),
    .o_pstrb   (pstrb),
    .i_prdata  (prdata),
    .i_pready  (pready),
    .i_pslverr (pslverr)
  );

  data_ram u_data_ram (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .i_pstrb   (pstrb),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr)
  );

endmodule

// ==== tb/tb_mem_subsys.sv ====
// testbench for the memory subsystem, checks the write-back stream against a byte model of the RAM

`timescale 1ns/10ps

module tb_mem_subsys
  import mem_pkg::*;
();

  typedef struct packed {
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [WORD_WD-1:0]     gpr_data;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr;
    logic [WORD_WD-1:0]     csr_data;
    logic                   mem_err;
  } wb_t;

  localparam int INIT_WORDS = 64;  // words written before any load

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_es_valid;
  logic [GPR_ADDR_WD-1:0] i_rd;
  logic [CSR_ADDR_WD-1:0] i_csr;
  logic                   i_gpr_wen;
  logic                   i_csr_wen;
  logic                   i_mem_ren;
  logic                   i_mem_wen;
  mem_op_e                i_mem_op;
  logic                   i_csr_inst_sel;
  logic [WORD_WD-1:0]     i_rs2data;
  logic [WORD_WD-1:0]     i_csrrdata;
  logic [WORD_WD-1:0]     i_alu_result;
  logic [WORD_WD-1:0]     i_csr_result;
  logic                   o_ms_allow_in;
  logic                   o_ws_valid;
  logic                   o_ws_gpr_wen;
  logic [GPR_ADDR_WD-1:0] o_ws_rd;
  logic [WORD_WD-1:0]     o_ws_gpr_data;
  logic                   o_ws_csr_wen;
  logic [CSR_ADDR_WD-1:0] o_ws_csr;
  logic [WORD_WD-1:0]     o_ws_csr_data;
  logic                   o_ws_mem_err;
  logic                   i_ws_allow_in;

  logic [7:0] model_mem [DMEM_WORDS*4];  // byte model of the data RAM
  wb_t        want_q [$];
  int         seed;
  int         bp_mode;    // 0 always ready, 1 random, 2 mostly stalled
  int         n_sent;
  int         n_checked;
  int         n_err;
  int         cyc;

  mem_subsys i_mem_subsys (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic int op_size(input mem_op_e op);
    case (op)
      MEM_W:        return 4;
      MEM_H, MEM_HU: return 2;
      default:      return 1;
    endcase
  endfunction

  // expected write-back of one instruction, updates the model on stores
  function automatic wb_t ref_result(
    input logic [GPR_ADDR_WD-1:0] rd, input logic [CSR_ADDR_WD-1:0] csr,
    input logic gpr_wen, input logic csr_wen, input logic ren, input logic wen,
    input mem_op_e op, input logic csr_sel, input logic [WORD_WD-1:0] rs2,
    input logic [WORD_WD-1:0] csrr, input logic [WORD_WD-1:0] alu,
    input logic [WORD_WD-1:0] csr_res);
    wb_t                r;
    logic               bad;
    logic [WORD_WD-1:0] v;
    int                 n;
    int                 base;
    n = op_size(op);
    bad = 1'b0;
    if (ren || wen) begin
      if ((n == 4 && alu[1:0] != 2'b00) || (n == 2 && alu[0]))
        bad = 1'b1;
      if (alu >= 32'(DMEM_WORDS * 4))
        bad = 1'b1;
    end
    base = int'(alu[9:0]);
    v = '0;
    if (!bad && wen) begin
      for (int i = 0; i < n; i++)
        model_mem[base + i] = rs2[8*i +: 8];  // low bytes of rs2, little endian
    end
    if (!bad && ren) begin
      for (int i = 0; i < n; i++)
        v[8*i +: 8] = model_mem[base + i];
      if (op == MEM_B)
        v = {{24{v[7]}}, v[7:0]};
      else if (op == MEM_H)
        v = {{16{v[15]}}, v[15:0]};
    end
    r.gpr_wen  = gpr_wen;
    r.rd       = rd;
    r.csr_wen  = csr_wen;
    r.csr      = csr;
    r.csr_data = csr_res;
    r.mem_err  = bad;
    if (bad)
      r.gpr_data = '0;
    else if (ren)
      r.gpr_data = v;
    else if (csr_sel)
      r.gpr_data = csrr;
    else
      r.gpr_data = alu;
    return r;
  endfunction

  task automatic value_error(input string name, input logic [31:0] want, input logic [31:0] got);
    n_err++;
    $display("error %s: expected %h, got %h", name, want, got);
  endtask

  task automatic send_inst(
    input logic [GPR_ADDR_WD-1:0] rd, input logic [CSR_ADDR_WD-1:0] csr,
    input logic gpr_wen, input logic csr_wen, input logic ren, input logic wen,
    input mem_op_e op, input logic csr_sel, input logic [WORD_WD-1:0] rs2,
    input logic [WORD_WD-1:0] csrr, input logic [WORD_WD-1:0] alu,
    input logic [WORD_WD-1:0] csr_res);
    wb_t want;
    bit  ok;
    want = ref_result(rd, csr, gpr_wen, csr_wen, ren, wen, op, csr_sel, rs2, csrr, alu, csr_res);
    i_rd           = rd;
    i_csr          = csr;
    i_gpr_wen      = gpr_wen;
    i_csr_wen      = csr_wen;
    i_mem_ren      = ren;
    i_mem_wen      = wen;
    i_mem_op       = op;
    i_csr_inst_sel = csr_sel;
    i_rs2data      = rs2;
    i_csrrdata     = csrr;
    i_alu_result   = alu;
    i_csr_result   = csr_res;
    i_es_valid     = 1'b1;
    forever begin
      @(negedge i_clk);
      ok = o_ms_allow_in;
      @(posedge i_clk);
      #1;
      if (ok)
        break;
    end
    i_es_valid = 1'b0;
    want_q.push_back(want);
    n_sent++;
  endtask

  task automatic store_to(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
    send_inst(5'd0, 12'h000, 1'b0, 1'b0, 1'b0, 1'b1, op, 1'b0, data, 32'h0, addr, 32'h0);
  endtask

  task automatic load_from(input mem_op_e op, input logic [31:0] addr, input logic [4:0] rd);
    send_inst(rd, 12'h000, 1'b1, 1'b0, 1'b1, 1'b0, op, 1'b0, 32'h0, 32'hdead_beef, addr, 32'h0);
  endtask

  task automatic random_inst();
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] a;
    mem_op_e     op;
    r = $random(seed);
    d = $random(seed);
    a = {24'b0, r[13:8], r[21:20]};
    case (r[18:16])
      3'd0, 3'd5: op = MEM_B;
      3'd1, 3'd6: op = MEM_H;
      3'd3:       op = MEM_BU;
      3'd4:       op = MEM_HU;
      default:    op = MEM_W;
    endcase
    if (op_size(op) == 4)
      a[1:0] = 2'b00;
    else if (op_size(op) == 2)
      a[0] = 1'b0;
    case (r[2:0])
      3'd3, 3'd4: load_from(op, a, r[28:24]);
      3'd5, 3'd6: store_to(op == MEM_BU ? MEM_B : op == MEM_HU ? MEM_H : op, a, d);
      3'd7: begin
        if (r[6]) begin
          a = a + 32'h400;  // beyond the RAM
        end else begin
          op = r[7] ? MEM_W : MEM_H;
          a[0] = 1'b1;
        end
        if (r[5])
          store_to(op == MEM_BU ? MEM_B : op == MEM_HU ? MEM_H : op, a, d);
        else
          load_from(op, a, r[28:24]);
      end
      default: send_inst(r[28:24], d[11:0], r[3], r[4], 1'b0, 1'b0, MEM_W, r[5],
                         32'h0, $random(seed), d, $random(seed));
    endcase
  endtask

  task automatic drain();
    while (want_q.size() != 0)
      @(posedge i_clk);
    @(posedge i_clk);
    #1;
  endtask

  task automatic end_test(input string name, input int err0, input int chk0);
    drain();
    $display("test %-12s %0d results checked, %0d errors", name, n_checked - chk0, n_err - err0);
  endtask

  // write-back side ready, changes 1 ns after the edge
  initial begin : ws_ready
    logic [31:0] r;
    i_ws_allow_in = 1'b1;
    forever begin
      @(negedge i_clk);
      r = $random(seed);
      @(posedge i_clk);
      #1;
      case (bp_mode)
        0:       i_ws_allow_in = 1'b1;
        1:       i_ws_allow_in = (r[1:0] != 2'b00);
        default: i_ws_allow_in = (r[2:0] == 3'b000);
      endcase
    end
  end

  // compare at the falling edge where all outputs are settled
  initial begin : compare
    wb_t cur;
    wb_t held_val;
    wb_t want;
    bit  held;
    held = 1'b0;
    forever begin
      @(negedge i_clk);
      if (i_rst_n) begin
        cur = {o_ws_gpr_wen, o_ws_rd, o_ws_gpr_data, o_ws_csr_wen, o_ws_csr, o_ws_csr_data,
               o_ws_mem_err};
        if (held && !o_ws_valid) begin
          n_err++;
          $display("o_ws_valid dropped while the write-back side was stalled");
        end else if (held && cur !== held_val) begin
          n_err++;
          $display("error o_ws_* while stalled: expected %h, got %h", held_val, cur);
        end
        if (o_ws_valid && i_ws_allow_in) begin
          if (want_q.size() == 0) begin
            n_err++;
            $display("a write-back transfer came with no instruction outstanding");
          end else begin
            want = want_q.pop_front();
            if (o_ws_gpr_wen !== want.gpr_wen)
              value_error("o_ws_gpr_wen", 32'(want.gpr_wen), 32'(o_ws_gpr_wen));
            if (o_ws_rd !== want.rd)
              value_error("o_ws_rd", 32'(want.rd), 32'(o_ws_rd));
            if (o_ws_gpr_data !== want.gpr_data)
              value_error("o_ws_gpr_data", want.gpr_data, o_ws_gpr_data);
            if (o_ws_csr_wen !== want.csr_wen)
              value_error("o_ws_csr_wen", 32'(want.csr_wen), 32'(o_ws_csr_wen));
            if (o_ws_csr !== want.csr)
              value_error("o_ws_csr", 32'(want.csr), 32'(o_ws_csr));
            if (o_ws_csr_data !== want.csr_data)
              value_error("o_ws_csr_data", want.csr_data, o_ws_csr_data);
            if (o_ws_mem_err !== want.mem_err)
              value_error("o_ws_mem_err", 32'(want.mem_err), 32'(o_ws_mem_err));
            n_checked++;
          end
        end
        held = o_ws_valid && !i_ws_allow_in;
        held_val = cur;
      end
    end
  end

  initial begin : watchdog
    cyc = 0;
    forever begin
      @(posedge i_clk);
      cyc++;
      if (cyc > 40 * n_sent + 100) begin
        $display("timeout after %0d cycles, %0d instructions sent, %0d results still due",
                 cyc, n_sent, want_q.size());
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  end

  initial begin : stimulus
    int e0;
    int c0;
    seed = 32'hd5153c83;
    bp_mode = 0;
    n_sent = 0;
    n_checked = 0;
    n_err = 0;
    i_rst_n = 1'b0;
    i_es_valid = 1'b0;
    i_rd = '0;
    i_csr = '0;
    i_gpr_wen = 1'b0;
    i_csr_wen = 1'b0;
    i_mem_ren = 1'b0;
    i_mem_wen = 1'b0;
    i_mem_op = MEM_W;
    i_csr_inst_sel = 1'b0;
    i_rs2data = '0;
    i_csrrdata = '0;
    i_alu_result = '0;
    i_csr_result = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    e0 = n_err;
    c0 = n_checked;
    for (int w = 0; w < INIT_WORDS; w++)
      store_to(MEM_W, 32'(w * 4), (32'(w) * 32'h0101_0101) ^ 32'ha5c3_0f69);
    end_test("fill", e0, c0);

    e0 = n_err;
    c0 = n_checked;
    for (int i = 0; i < 16; i++)
      send_inst(5'(i), 12'(12'h300 + i), i[1], i[2], 1'b0, 1'b0, MEM_W, i[0],
                32'h0, $random(seed), $random(seed), $random(seed));
    end_test("alu_csr", e0, c0);

    e0 = n_err;
    c0 = n_checked;
    for (int off = 0; off < 4; off++) begin
      store_to(MEM_B, 32'(32 + off), $random(seed));
      load_from(MEM_W, 32'd32, 5'd1);
    end
    for (int off = 0; off < 4; off += 2) begin
      store_to(MEM_H, 32'(36 + off), $random(seed));
      load_from(MEM_W, 32'd36, 5'd2);
    end
    store_to(MEM_W, 32'd40, $random(seed));
    load_from(MEM_W, 32'd40, 5'd3);
    store_to(MEM_W, 32'd44, 32'h80ff_7f80);  // sign bits set and clear per lane
    load_from(MEM_W, 32'd44, 5'd4);
    end_test("stores", e0, c0);

    e0 = n_err;
    c0 = n_checked;
    for (int w = 8; w < 12; w++) begin
      for (int off = 0; off < 4; off++) begin
        load_from(MEM_B, 32'(w * 4 + off), 5'd5);
        load_from(MEM_BU, 32'(w * 4 + off), 5'd6);
        if (off % 2 == 0) begin
          load_from(MEM_H, 32'(w * 4 + off), 5'd7);
          load_from(MEM_HU, 32'(w * 4 + off), 5'd8);
        end
      end
      load_from(MEM_W, 32'(w * 4), 5'd9);
    end
    end_test("loads", e0, c0);

    e0 = n_err;
    c0 = n_checked;
    load_from(MEM_H, 32'd45, 5'd10);
    load_from(MEM_HU, 32'd47, 5'd11);
    load_from(MEM_W, 32'd42, 5'd12);
    load_from(MEM_W, 32'd41, 5'd13);
    store_to(MEM_H, 32'd45, 32'h1234_5678);
    store_to(MEM_W, 32'd46, 32'h9abc_def0);
    load_from(MEM_W, 32'h0000_0400, 5'd14);
    load_from(MEM_B, 32'h0000_0fff, 5'd15);
    store_to(MEM_W, 32'h0000_0400, 32'h5555_aaaa);  // would alias word 0
    store_to(MEM_B, 32'h8000_0001, 32'h0000_00ee);
    load_from(MEM_W, 32'd44, 5'd16);
    load_from(MEM_W, 32'd0, 5'd17);
    end_test("bad_access", e0, c0);

    e0 = n_err;
    c0 = n_checked;
    bp_mode = 2;
    for (int i = 0; i < 40; i++)
      random_inst();
    end_test("backpressure", e0, c0);

    e0 = n_err;
    c0 = n_checked;
    bp_mode = 1;
    for (int i = 0; i < 300; i++)
      random_inst();
    end_test("random", e0, c0);

    $display("%0d instructions sent, %0d results checked, %0d errors", n_sent, n_checked, n_err);
    if (n_err == 0 && n_checked == n_sent)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== sim.f ====
hw/mem_pkg.sv
hw/data_ram.sv
hw/lsu.sv
hw/mem_stage.sv
hw/mem_subsys.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build for the memory subsystem

VERILATOR ?= verilator
TB_TOP    ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys
FILELIST  ?= sim.f
RTL_SRCS  ?= hw/mem_pkg.sv hw/data_ram.sv hw/lsu.sv hw/mem_stage.sv hw/mem_subsys.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --assert $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
